/* source/bimodalPkg.sv */
package bimodalPkg;

  // program counter width
  localparam int PcWidth = 32;

  // byte offset bits below the instruction word
  localparam int InstByteOffset = 2;

  // 2-bit saturating counter
  localparam int CntWidth = 2;

  // every entry starts weakly taken
  localparam logic [CntWidth-1:0] CntInit = 2'd2;

  // saturation limits
  localparam logic [CntWidth-1:0] CntMax = 2'd3;
  localparam logic [CntWidth-1:0] CntMin = 2'd0;

  // weakly and strongly taken both predict taken
  localparam logic [CntWidth-1:0] TakenThreshold = 2'd2;

endpackage

/* source/counterInit.sv */
module counterInit #(
  parameter int FetchWidth  = 4,
  parameter int CntTableLog = 8
) (
  input  logic                                           clk,
  input  logic                                           resetRams_i,
  output logic                                           initEn_o,
  output logic [CntTableLog-$clog2(FetchWidth)-1:0]      initRow_o,
  output logic                                           ready_o
);

  localparam int BankLog     = $clog2(FetchWidth);
  localparam int RowWidth    = CntTableLog - BankLog;
  localparam int RowsPerBank = 1 << RowWidth;

  // state encodings
  localparam logic [1:0] StStart = 2'd0;
  localparam logic [1:0] StRun   = 2'd1;
  localparam logic [1:0] StDone  = 2'd2;

  logic [1:0]          state;
  logic [1:0]          nextState;
  logic [RowWidth-1:0] rowCnt;
  logic [RowWidth-1:0] nextRow;

  always_ff @(posedge clk or posedge resetRams_i)
  begin
    if (resetRams_i)
    begin
      state  <= StStart;
      rowCnt <= '0;
    end
    else
    begin
      state  <= nextState;
      rowCnt <= nextRow;
    end
  end

  always_comb
  begin
    nextState = state;
    nextRow   = rowCnt;
    initEn_o  = 1'b0;
    case (state)
      // one idle cycle after reset
      StStart:
      begin
        nextState = StRun;
        nextRow   = '0;
      end
      // one row per cycle, all banks at once
      StRun:
      begin
        initEn_o = 1'b1;
        nextRow  = rowCnt + 1'b1;
        if (rowCnt == RowWidth'(RowsPerBank - 1))
          nextState = StDone;
      end
      // park here until the next reset
      default:
      begin
        nextState = StDone;
        nextRow   = '0;
      end
    endcase
  end

  assign initRow_o = rowCnt;

  // low in start and run, so no glitch after reset
  assign ready_o = (state == StDone);

endmodule

/* source/counterTable.sv */
module counterTable import bimodalPkg::*; #(
  parameter int FetchWidth  = 4,
  parameter int CntTableLog = 8
) (
  input  logic                                                    clk,
  input  logic                                                    initEn_i,
  input  logic [CntTableLog-$clog2(FetchWidth)-1:0]               initRow_i,
  input  logic [CntTableLog-$clog2(FetchWidth)-1:0]               updRow_i,
  input  logic [FetchWidth-1:0]                                   updBankEn_i,
  input  logic [CntWidth-1:0]                                     updCounter_i,
  input  logic [FetchWidth-1:0][CntTableLog-$clog2(FetchWidth)-1:0] bankRow_i,
  output logic [FetchWidth-1:0][CntWidth-1:0]                     bankCounter_o
);

  localparam int BankLog     = $clog2(FetchWidth);
  localparam int RowWidth    = CntTableLog - BankLog;
  localparam int RowsPerBank = 1 << RowWidth;

  // shared write row and data for all banks
  logic [RowWidth-1:0]   wrRow;
  logic [CntWidth-1:0]   wrData;
  logic [FetchWidth-1:0] wrEn;

  // init wins, so an update during the sweep is dropped
  assign wrRow  = initEn_i ? initRow_i : updRow_i;
  assign wrData = initEn_i ? CntInit : updCounter_i;
  assign wrEn   = initEn_i ? {FetchWidth{1'b1}} : updBankEn_i;

  for (genvar b = 0; b < FetchWidth; b++)
  begin : bankGen
    // one row per bank entry
    logic [CntWidth-1:0] mem [RowsPerBank];

    always_ff @(posedge clk)
    begin
      if (wrEn[b])
        mem[wrRow] <= wrData;
    end

    // async read, each bank at its own row
    assign bankCounter_o[b] = mem[bankRow_i[b]];
  end

endmodule

/* source/fetchIndexer.sv */
module fetchIndexer import bimodalPkg::*; #(
  parameter int FetchWidth  = 4,
  parameter int CntTableLog = 8
) (
  input  logic [PcWidth-1:0]                                        pc_i,
  output logic [FetchWidth-1:0][CntTableLog-$clog2(FetchWidth)-1:0] bankRow_o,
  output logic [$clog2(FetchWidth)-1:0]                             startBank_o
);

  localparam int BankLog   = $clog2(FetchWidth);
  localparam int RowWidth  = CntTableLog - BankLog;
  localparam int InstWidth = PcWidth - InstByteOffset;

  // instruction number of the first lane
  logic [InstWidth-1:0]                 instNum;
  logic [BankLog-1:0]                   startBank;

  // per lane instruction number and row
  logic [FetchWidth-1:0][InstWidth-1:0] laneNum;
  logic [FetchWidth-1:0][RowWidth-1:0]  laneRow;

  assign instNum   = pc_i[PcWidth-1:InstByteOffset];
  assign startBank = instNum[BankLog-1:0];

  always_comb
  begin
    for (int i = 0; i < FetchWidth; i++)
    begin
      laneNum[i] = instNum + InstWidth'(i);
      // bits above the bank field, truncation gives modulo rows per bank
      laneRow[i] = laneNum[i][BankLog +: RowWidth];
    end
  end

  // bank b serves lane (b - startBank) mod FetchWidth
  always_comb
  begin
    logic [BankLog-1:0] laneSel;
    for (int b = 0; b < FetchWidth; b++)
    begin
      laneSel      = BankLog'(b) - startBank;
      bankRow_o[b] = laneRow[laneSel];
    end
  end

  // aligner needs the same rotation amount
  assign startBank_o = startBank;

endmodule

/* source/predictionAlign.sv */
module predictionAlign import bimodalPkg::*; #(
  parameter int FetchWidth = 4
) (
  input  logic [$clog2(FetchWidth)-1:0]       startBank_i,
  input  logic [FetchWidth-1:0][CntWidth-1:0] bankCounter_i,
  output logic [FetchWidth-1:0][CntWidth-1:0] predCounter_o,
  output logic [FetchWidth-1:0]               predDir_o
);

  localparam int BankLog = $clog2(FetchWidth);

  // counters back in lane order
  logic [FetchWidth-1:0][CntWidth-1:0] laneCounter;

  // lane i reads bank (startBank + i) mod FetchWidth
  always_comb
  begin
    logic [BankLog-1:0] bankSel;
    for (int i = 0; i < FetchWidth; i++)
    begin
      bankSel        = startBank_i + BankLog'(i);
      laneCounter[i] = bankCounter_i[bankSel];
    end
  end

  // taken for weakly or strongly taken
  always_comb
  begin
    for (int i = 0; i < FetchWidth; i++)
    begin
      predDir_o[i] = (laneCounter[i] >= TakenThreshold);
    end
  end

  assign predCounter_o = laneCounter;

endmodule

/* source/counterUpdate.sv */
module counterUpdate import bimodalPkg::*; #(
  parameter int FetchWidth  = 4,
  parameter int CntTableLog = 8
) (
  input  logic [PcWidth-1:0]                          updatePc_i,
  input  logic                                        updateDir_i,
  input  logic [CntWidth-1:0]                         updateCounter_i,
  input  logic                                        updateEn_i,
  output logic [CntTableLog-$clog2(FetchWidth)-1:0]   updRow_o,
  output logic [FetchWidth-1:0]                       updBankEn_o,
  output logic [CntWidth-1:0]                         updCounter_o
);

  localparam int BankLog  = $clog2(FetchWidth);
  localparam int RowWidth = CntTableLog - BankLog;

  // bank of the branch being retired
  logic [BankLog-1:0] updBank;

  // saturating step toward the resolved direction
  always_comb
  begin
    if (updateDir_i)
      updCounter_o = (updateCounter_i == CntMax) ? CntMax : updateCounter_i + 1'b1;
    else
      updCounter_o = (updateCounter_i == CntMin) ? CntMin : updateCounter_i - 1'b1;
  end

  // same field split as the fetch side, lane 0
  assign updBank  = updatePc_i[InstByteOffset +: BankLog];
  assign updRow_o = updatePc_i[InstByteOffset + BankLog +: RowWidth];

  // one hot bank write enable
  always_comb
  begin
    for (int b = 0; b < FetchWidth; b++)
    begin
      updBankEn_o[b] = updateEn_i && (updBank == BankLog'(b));
    end
  end

endmodule

/* source/bimodalPredictor.sv */
module bimodalPredictor import bimodalPkg::*; #(
  parameter int FetchWidth  = 4,
  parameter int CntTableLog = 8
) (
  input  logic                                clk,
  input  logic                                resetRams_i,
  input  logic [PcWidth-1:0]                  pc_i,
  input  logic [PcWidth-1:0]                  updatePc_i,
  input  logic                                updateDir_i,
  input  logic [CntWidth-1:0]                 updateCounter_i,
  input  logic                                updateEn_i,
  output logic [FetchWidth-1:0]               predDir_o,
  output logic [FetchWidth-1:0][CntWidth-1:0] predCounter_o,
  output logic                                ready_o
);

  // bank select and row widths
  localparam int BankLog  = $clog2(FetchWidth);
  localparam int RowWidth = CntTableLog - BankLog;

  // initialiser to table
  logic                                initEn;
  logic [RowWidth-1:0]                 initRow;

  // update port
  logic [RowWidth-1:0]                 updRow;
  logic [FetchWidth-1:0]               updBankEn;
  logic [CntWidth-1:0]                 updCounter;

  // fetch read path
  logic [FetchWidth-1:0][RowWidth-1:0] bankRow;
  logic [BankLog-1:0]                  startBank;
  logic [FetchWidth-1:0][CntWidth-1:0] bankCounter;

  // fills the table with weakly taken after resetRams_i
  counterInit #(
    .FetchWidth  (FetchWidth),
    .CntTableLog (CntTableLog)
  ) init (
    .clk         (clk),
    .resetRams_i (resetRams_i),
    .initEn_o    (initEn),
    .initRow_o   (initRow),
    .ready_o     (ready_o)
  );

  // banked counter storage
  counterTable #(
    .FetchWidth    (FetchWidth),
    .CntTableLog   (CntTableLog)
  ) table0 (
    .clk           (clk),
    .initEn_i      (initEn),
    .initRow_i     (initRow),
    .updRow_i      (updRow),
    .updBankEn_i   (updBankEn),
    .updCounter_i  (updCounter),
    .bankRow_i     (bankRow),
    .bankCounter_o (bankCounter)
  );

  // fetch pc to per-bank read rows
  fetchIndexer #(
    .FetchWidth  (FetchWidth),
    .CntTableLog (CntTableLog)
  ) indexer (
    .pc_i        (pc_i),
    .bankRow_o   (bankRow),
    .startBank_o (startBank)
  );

  // bank data back to lane order
  predictionAlign #(
    .FetchWidth    (FetchWidth)
  ) align (
    .startBank_i   (startBank),
    .bankCounter_i (bankCounter),
    .predCounter_o (predCounter_o),
    .predDir_o     (predDir_o)
  );

  // next counter value and write decode
  counterUpdate #(
    .FetchWidth      (FetchWidth),
    .CntTableLog     (CntTableLog)
  ) update (
    .updatePc_i      (updatePc_i),
    .updateDir_i     (updateDir_i),
    .updateCounter_i (updateCounter_i),
    .updateEn_i      (updateEn_i),
    .updRow_o        (updRow),
    .updBankEn_o     (updBankEn),
    .updCounter_o    (updCounter)
  );

endmodule

/* dv/bimodalChecker.sv */
module bimodalChecker import bimodalPkg::*; #(
  parameter int FetchWidth  = 4,
  parameter int CntTableLog = 8
) (
  input logic                                clk,
  input logic                                resetRams_i,
  input logic [PcWidth-1:0]                  pc_i,
  input logic [PcWidth-1:0]                  updatePc_i,
  input logic                                updateDir_i,
  input logic [CntWidth-1:0]                 updateCounter_i,
  input logic                                updateEn_i,
  input logic [FetchWidth-1:0]               predDir_i,
  input logic [FetchWidth-1:0][CntWidth-1:0] predCounter_i,
  input logic                                ready_i,
  input logic                                checkEn_i,
  input logic                                stimValid_i,
  input logic [FetchWidth-1:0][CntWidth-1:0] stimExp_i
);

  localparam int RowsPerBank = (1 << CntTableLog) / FetchWidth;

  // reference copy of the table, bank then row
  logic [CntWidth-1:0] shadow [FetchWidth][RowsPerBank];

  // rising edges since resetRams_i fell
  int    edgeCount;
  bit    readySeen;
  string testName   = "";
  int    testChecks = 0;
  int    testErrors = 0;
  int    testCount  = 0;
  int    checkCount = 0;
  int    errorCount = 0;

  // instruction number plus lane, bank from low bits, row from the rest
  function automatic logic [CntWidth-1:0] modelLane(input logic [PcWidth-1:0] pc, input int lane);
    logic [PcWidth-1:0] inst;
    inst = (pc >> InstByteOffset) + PcWidth'(lane);
    return shadow[inst % FetchWidth][(inst / FetchWidth) % RowsPerBank];
  endfunction

  task automatic reportMismatch(input string what, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    testErrors++;
    errorCount++;
    $display("Fail %s: %s at pc %h expected %h actual %h",
             testName, what, pc_i, expVal, actVal);
  endtask

  task automatic compareLanes();
    logic [FetchWidth-1:0][CntWidth-1:0] modelCnt;
    logic [FetchWidth-1:0]               modelDir;
    for (int i = 0; i < FetchWidth; i++)
    begin
      modelCnt[i] = modelLane(pc_i, i);
      // 2 and 3 predict taken
      modelDir[i] = (modelCnt[i] >= TakenThreshold);
    end
    testChecks++;
    checkCount++;
    if (stimValid_i && predCounter_i !== stimExp_i)
      reportMismatch("stim counters", stimExp_i, predCounter_i);
    if (predCounter_i !== modelCnt)
      reportMismatch("model counters", modelCnt, predCounter_i);
    if (predDir_i !== modelDir)
      reportMismatch("directions", modelDir, predDir_i);
  endtask

  // step toward the resolved direction, hold at the ends
  task automatic mirrorUpdate();
    logic [PcWidth-1:0]  inst;
    logic [CntWidth-1:0] next;
    inst = updatePc_i >> InstByteOffset;
    next = updateCounter_i;
    if (updateDir_i && updateCounter_i != CntMax)
      next = updateCounter_i + 1;
    else if (!updateDir_i && updateCounter_i != CntMin)
      next = updateCounter_i - 1;
    shadow[inst % FetchWidth][(inst / FetchWidth) % RowsPerBank] = next;
  endtask

  always @(posedge clk or posedge resetRams_i)
  begin
    if (resetRams_i)
      edgeCount <= 0;
    else
      edgeCount <= edgeCount + 1;
  end

  // mid cycle, inputs and combinational outputs have settled
  always @(negedge clk)
  begin
    if (resetRams_i)
    begin
      foreach (shadow[b, r])
        shadow[b][r] = CntInit;
      readySeen = 1'b0;
    end
    else
    begin
      // start cycle plus one per row
      if (ready_i && !readySeen)
      begin
        readySeen = 1'b1;
        testChecks++;
        checkCount++;
        if (edgeCount != RowsPerBank + 1)
        begin
          testErrors++;
          errorCount++;
          $display("Fail %s: ready_o rise cycle expected %0d actual %0d",
                   testName, RowsPerBank + 1, edgeCount);
        end
      end
      // compare before the write of this cycle lands
      if (ready_i && checkEn_i)
        compareLanes();
      // sweep drops updates, and start cycle writes get overwritten
      if (ready_i && updateEn_i)
        mirrorUpdate();
    end
  end

  task automatic startTest(input string name);
    testName   = name;
    testChecks = 0;
    testErrors = 0;
  endtask

  task automatic finishTest();
    testCount++;
    $display("test %s done, %0d checks, %0d errors", testName, testChecks, testErrors);
  endtask

  task automatic noteProblem(input string msg);
    testErrors++;
    errorCount++;
    $display("%s: %s", testName, msg);
  endtask

endmodule

/* dv/bimodal_assert.sv */
module bimodalAssert import bimodalPkg::*; #(
  parameter int FetchWidth = 4
) (
  input logic                                clk,
  input logic                                resetRams_i,
  input logic                                initEn_i,
  input logic                                ready_i,
  input logic [FetchWidth-1:0]               predDir_i,
  input logic [FetchWidth-1:0][CntWidth-1:0] predCounter_i
);

  // read back by the testbench for the closing count
  int failCount = 0;

  // no prediction offered while the sweep still writes
  readyDuringInit: assert property (@(posedge clk) disable iff (resetRams_i)
    initEn_i |-> !ready_i)
  else
  begin
    failCount++;
    $error("ready_o is high while the initialiser writes the table");
  end

  // ready is a level, only reset clears it
  readyHolds: assert property (@(posedge clk) disable iff (resetRams_i)
    !$fell(ready_i))
  else
  begin
    failCount++;
    $error("ready_o fell without a reset");
  end

  // table fully written, so no x on the read path
  outputsKnown: assert property (@(posedge clk) disable iff (resetRams_i)
    ready_i |-> !$isunknown({predDir_i, predCounter_i}))
  else
  begin
    failCount++;
    $error("prediction outputs are unknown while ready_o is high");
  end

endmodule

bind bimodalPredictor bimodalAssert #(
  .FetchWidth    (FetchWidth)
) assertInst (
  .clk           (clk),
  .resetRams_i   (resetRams_i),
  .initEn_i      (initEn),
  .ready_i       (ready_o),
  .predDir_i     (predDir_o),
  .predCounter_i (predCounter_o)
);

/* dv/bimodalTb.sv */
module bimodalTb import bimodalPkg::*; ();

  localparam int    FetchWidth  = 4;
  localparam int    CntTableLog = 8;
  localparam int    RowsPerBank = (1 << CntTableLog) / FetchWidth;
  localparam int    ClkPeriod   = 20;
  localparam int    DriveDelay  = 2;
  localparam int    ResetCycles = 8;
  localparam int    RandCycles  = 200;
  localparam string StimFile    = "dv/bimodalStim.txt";

  logic                                clk;
  logic                                resetRams;
  logic [PcWidth-1:0]                  pc;
  logic [PcWidth-1:0]                  updatePc;
  logic                                updateDir;
  logic [CntWidth-1:0]                 updateCounter;
  logic                                updateEn;
  logic [FetchWidth-1:0]               predDir;
  logic [FetchWidth-1:0][CntWidth-1:0] predCounter;
  logic                                ready;

  // tells the checker what to compare this cycle
  logic                                checkEn;
  logic                                stimValid;
  logic [FetchWidth-1:0][CntWidth-1:0] stimExp;

  // records from the stim file
  string                               stimName [$];
  string                               stimOp [$];
  logic [PcWidth-1:0]                  stimPc [$];
  logic                                stimDir [$];
  logic [CntWidth-1:0]                 stimCnt [$];
  logic [FetchWidth-1:0][CntWidth-1:0] stimLanes [$];

  int watchLimit = 0;
  int totalErrors;
  bit stimOk;

  bimodalPredictor #(
    .FetchWidth      (FetchWidth),
    .CntTableLog     (CntTableLog)
  ) uut (
    .clk             (clk),
    .resetRams_i     (resetRams),
    .pc_i            (pc),
    .updatePc_i      (updatePc),
    .updateDir_i     (updateDir),
    .updateCounter_i (updateCounter),
    .updateEn_i      (updateEn),
    .predDir_o       (predDir),
    .predCounter_o   (predCounter),
    .ready_o         (ready)
  );

  bimodalChecker #(
    .FetchWidth      (FetchWidth),
    .CntTableLog     (CntTableLog)
  ) chk (
    .clk             (clk),
    .resetRams_i     (resetRams),
    .pc_i            (pc),
    .updatePc_i      (updatePc),
    .updateDir_i     (updateDir),
    .updateCounter_i (updateCounter),
    .updateEn_i      (updateEn),
    .predDir_i       (predDir),
    .predCounter_i   (predCounter),
    .ready_i         (ready),
    .checkEn_i       (checkEn),
    .stimValid_i     (stimValid),
    .stimExp_i       (stimExp)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // inputs change just after the edge
  task automatic step();
    @(posedge clk);
    #DriveDelay;
  endtask

  task automatic driveIdle();
    updateEn  = 1'b0;
    checkEn   = 1'b0;
    stimValid = 1'b0;
  endtask

  task automatic loadStim(output bit ok);
    int          fd;
    int          n;
    int          dirVal;
    int          cntVal;
    string       line;
    string       name;
    string       op;
    logic [31:0] pcVal;
    logic [31:0] expVal;
    ok = 1'b0;
    fd = $fopen(StimFile, "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        // skip column notes and blank lines
        if (line.len() > 2 && line.getc(0) != "#")
        begin
          n = $sscanf(line, "%s %s %h %d %d %h", name, op, pcVal, dirVal, cntVal, expVal);
          if (n == 6)
          begin
            stimName.push_back(name);
            stimOp.push_back(op);
            stimPc.push_back(pcVal);
            stimDir.push_back(dirVal[0]);
            stimCnt.push_back(CntWidth'(cntVal));
            stimLanes.push_back(expVal[FetchWidth*CntWidth-1:0]);
          end
        end
      end
      $fclose(fd);
      ok = (stimName.size() > 0);
    end
  endtask

  task automatic applyRecord(input int r);
    driveIdle();
    if (stimOp[r] == "predict")
    begin
      pc        = stimPc[r];
      stimExp   = stimLanes[r];
      stimValid = 1'b1;
      checkEn   = 1'b1;
    end
    else if (stimOp[r] == "update" || stimOp[r] == "sweep")
    begin
      updatePc      = stimPc[r];
      updateDir     = stimDir[r];
      updateCounter = stimCnt[r];
      updateEn      = 1'b1;
    end
    else
      chk.noteProblem($sformatf("unknown operation %s in the stim file", stimOp[r]));
  endtask

  // bounded wait for the end of the sweep
  task automatic waitReady();
    int n;
    n = 0;
    step();
    while (!ready && n < RowsPerBank + 8)
    begin
      step();
      n++;
    end
    if (!ready)
      chk.noteProblem("ready_o never rose after the table sweep");
  endtask

  task automatic runStim();
    string curName;
    bit    waited;
    curName = "";
    waited  = 1'b0;
    // rows 0 and 1 are swept before the first sweep record lands
    repeat (2) step();
    for (int r = 0; r < stimName.size(); r++)
    begin
      if (stimOp[r] != "sweep" && !waited)
      begin
        step();
        driveIdle();
        waitReady();
        waited = 1'b1;
      end
      else
        step();
      if (stimName[r] != curName)
      begin
        if (curName != "")
          chk.finishTest();
        chk.startTest(stimName[r]);
        curName = stimName[r];
      end
      applyRecord(r);
    end
  endtask

  task automatic runRandom();
    logic [PcWidth-1:0] inst;
    logic [PcWidth-1:0] lastUpd;
    step();
    chk.finishTest();
    chk.startTest("random");
    lastUpd = '0;
    for (int n = 0; n < RandCycles; n++)
    begin
      if (n > 0)
        step();
      driveIdle();
      if (n % 8 == 0)
      begin
        // group starts in the last row, later lanes wrap to row 0
        inst = PcWidth'((RowsPerBank - 1) * FetchWidth + 1 + $urandom_range(FetchWidth - 2));
        pc   = ($urandom << (CntTableLog + InstByteOffset)) | (inst << InstByteOffset);
      end
      else if (n % 3 == 1)
        pc = lastUpd;
      else
        pc = $urandom;
      checkEn       = 1'b1;
      updatePc      = $urandom;
      updateDir     = 1'($urandom_range(1));
      updateCounter = CntWidth'($urandom_range(3));
      updateEn      = 1'($urandom_range(1));
      lastUpd       = updatePc;
    end
    step();
    driveIdle();
    chk.finishTest();
  endtask

  initial
  begin
    void'($urandom(32'hf460));
    resetRams     = 1'b1;
    pc            = '0;
    updatePc      = '0;
    updateDir     = 1'b0;
    updateCounter = '0;
    updateEn      = 1'b0;
    checkEn       = 1'b0;
    stimValid     = 1'b0;
    stimExp       = '0;
    loadStim(stimOk);
    if (!stimOk)
    begin
      $display("could not read any record from %s", StimFile);
      $display("Test failed");
      $finish;
    end
    else
    begin
      watchLimit = (stimName.size() + RandCycles + RowsPerBank + 20) * ClkPeriod;
      repeat (ResetCycles) @(posedge clk);
      #DriveDelay;
      resetRams = 1'b0;
      runStim();
      runRandom();
      totalErrors = chk.errorCount + uut.assertInst.failCount;
      $display("%0d tests, %0d checks, %0d errors", chk.testCount, chk.checkCount,
               totalErrors);
      if (totalErrors == 0)
        $display("Test completed successfully");
      else
        $display("Test failed");
      $finish;
    end
  end

  // limit follows the record count and the sweep length
  initial
  begin
    wait (watchLimit > 0);
    #(watchLimit);
    $display("the run timed out before all tests finished");
    $display("Test failed");
    $finish;
  end

endmodule

/* bimodalPredictor.f */
source/bimodalPkg.sv
source/counterInit.sv
source/counterTable.sv
source/fetchIndexer.sv
source/predictionAlign.sv
source/counterUpdate.sv
source/bimodalPredictor.sv
dv/bimodalChecker.sv
dv/bimodal_assert.sv
dv/bimodalTb.sv

/* Bender.yml */
package:
  name: bimodalPredictor

sources:
  - source/bimodalPkg.sv
  - source/counterInit.sv
  - source/counterTable.sv
  - source/fetchIndexer.sv
  - source/predictionAlign.sv
  - source/counterUpdate.sv
  - source/bimodalPredictor.sv
  - target: simulation
    files:
      - dv/bimodalChecker.sv
      - dv/bimodal_assert.sv
      - dv/bimodalTb.sv

/* dv/bimodalStim.txt */
# test op pc dir counter expected, pc and expected in hex
# expected packs the lane counters with lane 0 in the low bits, unused for sweep and update
init          sweep   00000000 0 0 00
init          sweep   00000004 0 1 00
init          predict 00000000 0 0 aa
aligned       predict 00000100 0 0 aa
aligned       predict 0000010c 0 0 aa
aligned       predict 00000ff8 0 0 aa
saturate      update  00000040 1 2 00
saturate      predict 00000040 0 0 ab
saturate      update  00000040 1 3 00
saturate      predict 00000040 0 0 ab
saturate      update  00000040 0 3 00
saturate      predict 00000040 0 0 aa
saturate      update  00000040 0 2 00
saturate      predict 00000040 0 0 a9
saturate      update  00000040 0 1 00
saturate      predict 00000040 0 0 a8
saturate      update  00000040 0 0 00
saturate      predict 00000040 0 0 a8
crossRow      update  00000088 1 2 00
crossRow      update  0000008c 0 2 00
crossRow      update  00000090 0 1 00
crossRow      update  00000094 1 3 00
crossRow      predict 00000088 0 0 c7
crossRow      predict 00000084 0 0 1e
crossRow      predict 0000008c 0 0 b1
bankIsolation update  00000204 0 2 00
bankIsolation predict 00000200 0 0 a6
bankIsolation predict 00000214 0 0 aa
bankIsolation predict 00000104 0 0 aa
